/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - files:
      - rv_pkg.sv
      - fetch_unit.sv
      - id_stage.sv
      - reg_file.sv
      - exe_stage.sv
      - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv

/* exe_stage.sv */
// alu, branch and jump resolution, load extension, writeback and retire strobe
`timescale 1ns/10ps
`include "rv_defs.svh"

module exe_stage (
  input  rv_pkg::dec_t    dec,
  input  logic [`BUS_64]  dmem_rdata,
  output logic            dmem_ren,
  output logic [`BUS_64]  dmem_raddr,
  output logic            dmem_wen,
  output logic [`BUS_64]  dmem_waddr,
  output logic [`BUS_64]  dmem_wdata,
  output logic [`BUS_64]  dmem_wmask,
  output logic            wb_en,
  output logic [4:0]      wb_rd,
  output logic [`BUS_64]  wb_data,
  output logic [`BUS_64]  next_pc,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  logic [`BUS_64] alu_res;
  logic [`BUS_64] load_res;
  logic [`BUS_64] pc_plus4;
  logic           taken;
  logic           writes_rd;

  assign pc_plus4 = dec.pc + 64'd4;

  // op-imm and op share the alu, only op can subtract
  always_comb begin
    case (dec.funct3)
      F3_ADD: begin
        if (dec.opcode == OPC_OP && dec.funct7[5]) begin
          alu_res = dec.op1 - dec.op2;
        end else begin
          alu_res = dec.op1 + dec.op2;
        end
      end
      F3_SLT:  alu_res = {63'd0, ($signed(dec.op1) < $signed(dec.op2))};
      F3_XOR:  alu_res = dec.op1 ^ dec.op2;
      F3_OR:   alu_res = dec.op1 | dec.op2;
      F3_AND:  alu_res = dec.op1 & dec.op2;
      default: alu_res = 64'd0;
    endcase
  end

  // memory returns the addressed data in the low bits
  always_comb begin
    case (dec.funct3)
      F3_LB:   load_res = {{56{dmem_rdata[7]}}, dmem_rdata[7:0]};
      F3_LBU:  load_res = {56'd0, dmem_rdata[7:0]};
      F3_LW:   load_res = {{32{dmem_rdata[31]}}, dmem_rdata[31:0]};
      F3_LD:   load_res = dmem_rdata;
      default: load_res = 64'd0;
    endcase
  end

  assign taken = (dec.opcode == OPC_BRANCH) &&
                 (((dec.funct3 == F3_BEQ) && (dec.op1 == dec.op2)) ||
                  ((dec.funct3 == F3_BNE) && (dec.op1 != dec.op2)));

  always_comb begin
    case (dec.opcode)
      OPC_JAL:    next_pc = dec.op2;
      OPC_JALR:   next_pc = (dec.op1 + dec.op2) & ~64'd1;
      OPC_BRANCH: next_pc = taken ? dec.t1 : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
  end

  // writeback value per opcode
  always_comb begin
    case (dec.opcode)
      OPC_LUI:           wb_data = dec.t1;
      OPC_AUIPC:         wb_data = dec.op1 + dec.op2;
      OPC_JAL:           wb_data = dec.op1;
      OPC_JALR:          wb_data = dec.t1;
      OPC_LOAD:          wb_data = load_res;
      OPC_OPIMM, OPC_OP: wb_data = alu_res;
      default:           wb_data = 64'd0;
    endcase
  end

  assign writes_rd = dec.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                        OPC_LOAD, OPC_OPIMM, OPC_OP};
  assign wb_en = dec.valid && writes_rd && (dec.rd != 5'd0);
  assign wb_rd = dec.rd;

  // data memory follows the decoded fields directly
  assign dmem_ren   = dec.mem_ren;
  assign dmem_raddr = dec.mem_addr;
  assign dmem_wen   = dec.mem_wen;
  assign dmem_waddr = dec.mem_addr;
  assign dmem_wdata = dec.mem_wdata;
  assign dmem_wmask = dec.mem_wmask;

  // one pulse per instruction, in the decode phase
  assign retire_valid   = dec.valid;
  assign retire.pc      = dec.pc;
  assign retire.rd      = dec.rd;
  assign retire.wb_en   = wb_en;
  assign retire.wb_data = wb_data;

endmodule

/* fetch_unit.sv */
// pc register, instruction-cycle counter and fetched instruction latch
`timescale 1ns/10ps
`include "rv_defs.svh"

module fetch_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic [`BUS_32] imem_rdata,
  input  logic [`BUS_64] next_pc,
  output logic [`BUS_64] imem_addr,
  output logic [`BUS_8]  instcycle_cnt_val,
  output logic [`BUS_32] inst,
  output logic [`BUS_64] pc
);

  logic last_phase;
  logic fetch_phase;
  logic decode_phase;

  assign last_phase   = (instcycle_cnt_val == 8'(`INST_CYCLES - 1));
  assign fetch_phase  = (instcycle_cnt_val == 8'd0);
  assign decode_phase = (instcycle_cnt_val == 8'(`ID_PHASE));

  // phase counter 0..INST_CYCLES-1
  always_ff @(posedge clk) begin
    if (rst) begin
      instcycle_cnt_val <= 8'd0;
    end else if (last_phase) begin
      instcycle_cnt_val <= 8'd0;
    end else begin
      instcycle_cnt_val <= instcycle_cnt_val + 8'd1;
    end
  end

  // pc moves only when the instruction commits
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (decode_phase) begin
      pc <= next_pc;
    end
  end

  // capture the fetched word, held until the next fetch phase
  always_ff @(posedge clk) begin
    if (fetch_phase) begin
      inst <= imem_rdata;
    end
  end

  // address stays put for the whole instruction
  assign imem_addr = pc;

endmodule

/* flist.f */
+incdir+.
rv_pkg.sv
fetch_unit.sv
id_stage.sv
reg_file.sv
exe_stage.sv
rv_core.sv
tb_rv_core.sv

/* id_stage.sv */
// instruction decode, immediates, operand select, memory address and write mask
`timescale 1ns/10ps
`include "rv_defs.svh"

module id_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic [`BUS_8]  instcycle_cnt_val,
  input  logic [`BUS_32] inst,
  input  logic [`BUS_64] pc,
  input  logic [`BUS_64] rs1_data,
  input  logic [`BUS_64] rs2_data,
  output logic           rs1_ren,
  output logic [4:0]     rs1,
  output logic           rs2_ren,
  output logic [4:0]     rs2,
  output rv_pkg::dec_t   dec
);
  import rv_pkg::*;

  logic           id_active;
  opcode_e        opcode;
  logic [2:0]     funct3;
  itype_e         itype_nxt;
  itype_e         itype_q;
  logic [`BUS_64] imm_i;
  logic [`BUS_64] imm_s;
  logic [`BUS_64] imm_b;
  logic [`BUS_64] imm_u;
  logic [`BUS_64] imm_j;
  logic [`BUS_64] imm;
  logic [`BUS_64] pc_plus4;

  assign id_active = (instcycle_cnt_val == 8'(`ID_PHASE));

  assign opcode = opcode_e'(inst[6:2]);
  assign funct3 = inst[14:12];

  // sign-extended immediates
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign pc_plus4 = pc + 64'd4;

  // opcode classification
  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC:                     itype_nxt = ITYPE_U;
      OPC_JAL:                                itype_nxt = ITYPE_J;
      OPC_JALR, OPC_LOAD, OPC_OPIMM:          itype_nxt = ITYPE_I;
      OPC_FENCE, OPC_SYSTEM:                  itype_nxt = ITYPE_I;
      OPC_BRANCH:                             itype_nxt = ITYPE_B;
      OPC_STORE:                              itype_nxt = ITYPE_S;
      OPC_OP:                                 itype_nxt = ITYPE_R;
      default:                                itype_nxt = ITYPE_NONE;
    endcase
  end

  // type is settled well before decode since inst is stable from phase 1
  always_ff @(posedge clk) begin
    if (rst) begin
      itype_q <= ITYPE_NONE;
    end else begin
      itype_q <= itype_nxt;
    end
  end

  always_comb begin
    case (itype_q)
      ITYPE_I: imm = imm_i;
      ITYPE_S: imm = imm_s;
      ITYPE_B: imm = imm_b;
      ITYPE_U: imm = imm_u;
      ITYPE_J: imm = imm_j;
      default: imm = 64'd0;
    endcase
  end

  // register file read side
  assign rs1     = id_active ? inst[19:15] : 5'd0;
  assign rs2     = id_active ? inst[24:20] : 5'd0;
  assign rs1_ren = id_active &&
                   (itype_q inside {ITYPE_R, ITYPE_I, ITYPE_S, ITYPE_B});
  assign rs2_ren = id_active && (itype_q inside {ITYPE_R, ITYPE_S, ITYPE_B});

  // decode record, all zero outside the decode phase
  always_comb begin
    dec = '0;
    if (id_active) begin
      dec.valid  = 1'b1;
      dec.itype  = itype_q;
      dec.opcode = opcode;
      dec.funct3 = funct3;
      dec.funct7 = inst[31:25];
      dec.rd     = inst[11:7];
      dec.pc     = pc;

      case (itype_q)
        ITYPE_R, ITYPE_B: begin
          dec.op1 = rs1_data;
          dec.op2 = rs2_data;
        end
        ITYPE_I: begin
          dec.op1 = rs1_data;
          dec.op2 = imm;
        end
        ITYPE_J: begin
          dec.op1 = pc_plus4;
          dec.op2 = pc + imm;
        end
        ITYPE_U: begin
          // lui leaves both operands zero, value travels in t1
          dec.op1 = (opcode == OPC_AUIPC) ? pc : 64'd0;
          dec.op2 = (opcode == OPC_AUIPC) ? imm : 64'd0;
          dec.t1  = imm;
        end
        default: ;
      endcase

      // link address for jalr, target for branches
      if (opcode == OPC_JALR) begin
        dec.t1 = pc_plus4;
      end else if (opcode == OPC_BRANCH) begin
        dec.t1 = pc + imm;
      end

      // two's complement add covers the signed offset
      if (opcode == OPC_LOAD || itype_q == ITYPE_S) begin
        dec.mem_addr = rs1_data + imm;
      end
      dec.mem_ren = (opcode == OPC_LOAD);

      if (itype_q == ITYPE_S) begin
        dec.mem_wen   = 1'b1;
        dec.mem_wdata = rs2_data;
        // mask is low-aligned, memory shifts it to the address
        case (funct3)
          F3_SB:   dec.mem_wmask = 64'h0000_0000_0000_00FF;
          F3_SH:   dec.mem_wmask = 64'h0000_0000_0000_FFFF;
          F3_SW:   dec.mem_wmask = 64'h0000_0000_FFFF_FFFF;
          F3_SD:   dec.mem_wmask = 64'hFFFF_FFFF_FFFF_FFFF;
          default: dec.mem_wmask = 64'd0;
        endcase
      end
    end
  end

endmodule

/* reg_file.sv */
// 32 x 64-bit register file, x0 hardwired, two read ports and one write port
`timescale 1ns/10ps
`include "rv_defs.svh"

module reg_file (
  input  logic           clk,
  input  logic           rst,
  input  logic [4:0]     rs1,
  input  logic           rs1_ren,
  input  logic [4:0]     rs2,
  input  logic           rs2_ren,
  input  logic           wb_en,
  input  logic [4:0]     wb_rd,
  input  logic [`BUS_64] wb_data,
  output logic [`BUS_64] rs1_data,
  output logic [`BUS_64] rs2_data
);

  // x0 has no storage
  logic [`BUS_64] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 64'd0;
      end
    end else if (wb_en && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // disabled port or x0 reads zero
  always_comb begin
    rs1_data = 64'd0;
    if (rs1_ren && rs1 != 5'd0) begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    rs2_data = 64'd0;
    if (rs2_ren && rs2 != 5'd0) begin
      rs2_data = regs[rs2];
    end
  end

endmodule

/* rv_core.sv */
// top level joining fetch, decode, register file and execute to the memory ports
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core (
  input  logic            clk,
  input  logic            rst,
  input  logic [`BUS_32]  imem_rdata,
  input  logic [`BUS_64]  dmem_rdata,
  output logic [`BUS_64]  imem_addr,
  output logic            dmem_ren,
  output logic [`BUS_64]  dmem_raddr,
  output logic            dmem_wen,
  output logic [`BUS_64]  dmem_waddr,
  output logic [`BUS_64]  dmem_wdata,
  output logic [`BUS_64]  dmem_wmask,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  logic [`BUS_8]  instcycle_cnt_val;
  logic [`BUS_32] inst;
  logic [`BUS_64] pc;
  logic [`BUS_64] next_pc;
  logic           rs1_ren;
  logic [4:0]     rs1;
  logic           rs2_ren;
  logic [4:0]     rs2;
  logic [`BUS_64] rs1_data;
  logic [`BUS_64] rs2_data;
  logic           wb_en;
  logic [4:0]     wb_rd;
  logic [`BUS_64] wb_data;
  dec_t           dec;

  fetch_unit u_fetch (
    .clk               (clk),
    .rst               (rst),
    .imem_rdata        (imem_rdata),
    .next_pc           (next_pc),
    .imem_addr         (imem_addr),
    .instcycle_cnt_val (instcycle_cnt_val),
    .inst              (inst),
    .pc                (pc)
  );

  id_stage u_id (
    .clk               (clk),
    .rst               (rst),
    .instcycle_cnt_val (instcycle_cnt_val),
    .inst              (inst),
    .pc                (pc),
    .rs1_data          (rs1_data),
    .rs2_data          (rs2_data),
    .rs1_ren           (rs1_ren),
    .rs1               (rs1),
    .rs2_ren           (rs2_ren),
    .rs2               (rs2),
    .dec               (dec)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs1_ren  (rs1_ren),
    .rs2      (rs2),
    .rs2_ren  (rs2_ren),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exe_stage u_exe (
    .dec          (dec),
    .dmem_rdata   (dmem_rdata),
    .dmem_ren     (dmem_ren),
    .dmem_raddr   (dmem_raddr),
    .dmem_wen     (dmem_wen),
    .dmem_waddr   (dmem_waddr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wmask   (dmem_wmask),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .next_pc      (next_pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

/* rv_defs.svh */
// bus range macros, instruction phase count, decode phase and reset pc
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address bus range
`define BUS_64 63:0

// instruction bus range
`define BUS_32 31:0

// instruction-cycle counter range
`define BUS_8 7:0

// clock cycles spent on one instruction
`define INST_CYCLES 5

// phase in which decode and execute are active
// register, memory and pc updates commit on the edge ending it
`define ID_PHASE 4

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

/* rv_pkg.sv */
// opcode and instruction-type enums, funct3 names, decode and retire records
`include "rv_defs.svh"

package rv_pkg;

  // instruction bits 6..2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_FENCE  = 5'b00011,
    OPC_OPIMM  = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011,
    OPC_SYSTEM = 5'b11100
  } opcode_e;

  // encoding format, none for opcodes outside the slice
  typedef enum logic [2:0] {
    ITYPE_R    = 3'd0,
    ITYPE_I    = 3'd1,
    ITYPE_U    = 3'd2,
    ITYPE_S    = 3'd3,
    ITYPE_B    = 3'd4,
    ITYPE_J    = 3'd5,
    ITYPE_NONE = 3'd7
  } itype_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // load widths
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LD  = 3'b011;
  localparam logic [2:0] F3_LBU = 3'b100;

  // store widths
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_SD  = 3'b011;

  // alu functions, sub selected by funct7 bit 5 on OP
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  typedef struct packed {
    logic           valid;
    itype_e         itype;
    opcode_e        opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic [4:0]     rd;
    logic [`BUS_64] op1;
    logic [`BUS_64] op2;
    logic [`BUS_64] t1;
    logic           mem_ren;
    logic           mem_wen;
    logic [`BUS_64] mem_addr;
    logic [`BUS_64] mem_wdata;
    logic [`BUS_64] mem_wmask;
    logic [`BUS_64] pc;
  } dec_t;

  typedef struct packed {
    logic [`BUS_64] pc;
    logic [4:0]     rd;
    logic           wb_en;
    logic [`BUS_64] wb_data;
  } retire_t;

endpackage

/* tb_rv_core.sv */
// directed testbench for rv_core with memory models, reference model and watchdog
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int N_ARITH      = 18;
  localparam int N_UPPER      = 5;
  localparam int N_MEM        = 15;
  localparam int N_CTRL       = 13;
  localparam int N_TESTS      = 4;
  localparam int TOTAL_INSTS  = N_ARITH + N_UPPER + N_MEM + N_CTRL;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTS * `INST_CYCLES +
                                   N_TESTS * (RESET_CYCLES + 2) + 100;

  logic           clk = 1'b0;
  logic           rst;
  logic [`BUS_32] imem_rdata;
  logic [`BUS_64] dmem_rdata;
  logic [`BUS_64] imem_addr;
  logic           dmem_ren;
  logic [`BUS_64] dmem_raddr;
  logic           dmem_wen;
  logic [`BUS_64] dmem_waddr;
  logic [`BUS_64] dmem_wdata;
  logic [`BUS_64] dmem_wmask;
  logic           retire_valid;
  retire_t        retire;

  // instruction rom, data memory and the reference model state
  logic [`BUS_32] rom [0:63];
  logic [7:0]     dmem [0:255];
  logic [7:0]     sh_mem [0:255];
  logic [`BUS_64] sh_regs [0:31];
  logic [`BUS_64] sh_pc;
  int             prog_len;
  int             errors = 0;
  int             checks = 0;
  logic [31:0]    rng_state = 32'd35106;

  rv_core uut (
    .clk          (clk),
    .rst          (rst),
    .imem_rdata   (imem_rdata),
    .dmem_rdata   (dmem_rdata),
    .imem_addr    (imem_addr),
    .dmem_ren     (dmem_ren),
    .dmem_raddr   (dmem_raddr),
    .dmem_wen     (dmem_wen),
    .dmem_waddr   (dmem_waddr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wmask   (dmem_wmask),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign imem_rdata = rom[imem_addr[7:2]];

  // little-endian read, addressed byte lands in bits 7:0
  // bus reads zero unless the read strobe is up
  always_comb begin
    dmem_rdata = '0;
    if (dmem_ren) begin
      for (int i = 0; i < 8; i++) begin
        dmem_rdata[8*i +: 8] = dmem[8'(dmem_raddr[7:0] + i)];
      end
    end
  end

  // low-aligned byte mask applied from the write address upward
  always @(posedge clk) begin
    if (dmem_wen) begin
      for (int i = 0; i < 8; i++) begin
        if (dmem_wmask[8*i]) begin
          dmem[8'(dmem_waddr[7:0] + i)] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [4:0] rand_rd();
    return 5'(5 + next_rand() % 8);
  endfunction

  function automatic logic [4:0] rand_src();
    return 5'(1 + next_rand() % 12);
  endfunction

  // base is 64, keeps every access inside the 256-byte memory and aligned
  function automatic logic [11:0] rand_offset(input int size);
    int slot;
    int lane;
    slot = int'(next_rand() % 16) * 8 - 32;
    lane = int'(next_rand() % (8 / size)) * size;
    return 12'(slot + lane);
  endfunction

  // instruction encoders per format
  function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] r_word(input logic [4:0] rd, input logic [2:0] f3,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [6:0] f7);
    return {f7, rs2, rs1, f3, rd, OPC_OP, 2'b11};
  endfunction

  function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] u_word(input opcode_e op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL, 2'b11};
  endfunction

  task automatic emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic check_retire(input retire_t got, input retire_t expd);
    checks++;
    // pc is compared by check_pc
    if (got.rd !== expd.rd || got.wb_en !== expd.wb_en || got.wb_data !== expd.wb_data) begin
      errors++;
      $display("Mismatch at %0t: retire at pc %h got rd %0d wb_en %b data %h",
               $time, got.pc, got.rd, got.wb_en, got.wb_data);
      $display("  expected rd %0d wb_en %b data %h", expd.rd, expd.wb_en, expd.wb_data);
    end
  endtask

  task automatic check_word(input logic [`BUS_64] addr, input logic [`BUS_64] got,
                            input logic [`BUS_64] expd);
    checks++;
    if (got !== expd) begin
      errors++;
      $display("Mismatch at %0t: memory word %h got %h expected %h",
               $time, addr, got, expd);
    end
  endtask

  task automatic check_pc(input logic [`BUS_64] got, input logic [`BUS_64] expd);
    checks++;
    if (got !== expd) begin
      errors++;
      $display("Mismatch at %0t: retired pc %h expected %h", $time, got, expd);
    end
  endtask

  // reference model, one instruction per call
  task automatic step_model(input logic [31:0] w, output retire_t expd);
    opcode_e        op;
    logic [2:0]     f3;
    logic [4:0]     rd;
    logic [`BUS_64] a;
    logic [`BUS_64] b;
    logic [`BUS_64] rhs;
    logic [`BUS_64] addr;
    logic [`BUS_64] raw;
    logic [`BUS_64] res;
    logic [`BUS_64] npc;
    logic           writes;
    int             i;
    op     = opcode_e'(w[6:2]);
    f3     = w[14:12];
    rd     = w[11:7];
    a      = sh_regs[w[19:15]];
    b      = sh_regs[w[24:20]];
    npc    = sh_pc + 64'd4;
    res    = 64'd0;
    raw    = 64'd0;
    writes = 1'b0;
    case (op)
      OPC_LUI: begin
        res    = 64'($signed({w[31:12], 12'h000}));
        writes = 1'b1;
      end
      OPC_AUIPC: begin
        res    = sh_pc + 64'($signed({w[31:12], 12'h000}));
        writes = 1'b1;
      end
      OPC_JAL: begin
        res    = sh_pc + 64'd4;
        writes = 1'b1;
        npc    = sh_pc + 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      end
      OPC_JALR: begin
        res    = sh_pc + 64'd4;
        writes = 1'b1;
        npc    = (a + 64'($signed(w[31:20]))) & ~64'd1;
      end
      OPC_BRANCH: begin
        if ((f3 == F3_BEQ) ? (a == b) : (a != b)) begin
          npc = sh_pc + 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        end
      end
      OPC_LOAD: begin
        addr   = a + 64'($signed(w[31:20]));
        writes = 1'b1;
        for (i = 0; i < 8; i++) begin
          raw[8*i +: 8] = sh_mem[8'(addr[7:0] + i)];
        end
        case (f3)
          F3_LB:   res = 64'($signed(raw[7:0]));
          F3_LBU:  res = {56'd0, raw[7:0]};
          F3_LW:   res = 64'($signed(raw[31:0]));
          default: res = raw;
        endcase
      end
      OPC_STORE: begin
        addr = a + 64'($signed({w[31:25], w[11:7]}));
        for (i = 0; i < (1 << f3); i++) begin
          sh_mem[8'(addr[7:0] + i)] = b[8*i +: 8];
        end
      end
      OPC_OPIMM, OPC_OP: begin
        rhs    = (op == OPC_OP) ? b : 64'($signed(w[31:20]));
        writes = 1'b1;
        case (f3)
          F3_ADD:  res = (op == OPC_OP && w[30]) ? a - rhs : a + rhs;
          F3_SLT:  res = ($signed(a) < $signed(rhs)) ? 64'd1 : 64'd0;
          F3_XOR:  res = a ^ rhs;
          F3_OR:   res = a | rhs;
          default: res = a & rhs;
        endcase
      end
      default: ;
    endcase
    expd.pc      = sh_pc;
    expd.rd      = rd;
    expd.wb_en   = writes && (rd != 5'd0);
    expd.wb_data = writes ? res : 64'd0;
    if (expd.wb_en) begin
      sh_regs[rd] = res;
    end
    sh_pc = npc;
  endtask

  task automatic hold_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    if (retire_valid !== 1'b0 || dmem_wen !== 1'b0 || dmem_ren !== 1'b0) begin
      errors++;
      $display("Reset error at %0t: retire or memory strobe active during reset", $time);
    end
  endtask

  task automatic release_reset();
    @(posedge clk);
    rst <= 1'b0;
  endtask

  // reset, then clear rom, memories and the model
  task automatic start_test();
    int i;
    hold_reset();
    prog_len = 0;
    for (i = 0; i < 64; i++) begin
      rom[i] = i_word(OPC_OPIMM, 5'd0, F3_ADD, 5'd0, 12'(i));
    end
    for (i = 0; i < 256; i++) begin
      dmem[i]   = 8'(i * 167 + 13);
      sh_mem[i] = 8'(i * 167 + 13);
    end
    for (i = 0; i < 32; i++) begin
      sh_regs[i] = 64'd0;
    end
    sh_pc = `RESET_PC;
  endtask

  task automatic wait_retire(output int gap, output bit seen);
    gap = 0;
    do begin
      @(negedge clk);
      gap++;
    end while (retire_valid !== 1'b1 && gap < 4 * `INST_CYCLES);
    seen = (retire_valid === 1'b1);
    if (!seen) begin
      errors++;
      $display("Error at %0t: no retire pulse within %0d cycles", $time, gap);
    end
  endtask

  task automatic run_program(input int n_inst);
    retire_t        expd;
    logic [`BUS_32] word;
    int             gap;
    bit             seen;
    for (int k = 0; k < n_inst; k++) begin
      word = rom[sh_pc[7:2]];
      step_model(word, expd);
      wait_retire(gap, seen);
      if (!seen) begin
        return;
      end
      if (gap != `INST_CYCLES) begin
        errors++;
        $display("Timing error at %0t: retire came %0d cycles after the last, not %0d",
                 $time, gap, `INST_CYCLES);
      end
      check_pc(retire.pc, expd.pc);
      check_retire(retire, expd);
    end
  endtask

  task automatic arith_sequence();
    int i;
    start_test();
    for (i = 1; i <= 4; i++) begin
      emit(i_word(OPC_OPIMM, 5'(i), F3_ADD, 5'd0, 12'(next_rand())));
    end
    emit(i_word(OPC_OPIMM, rand_rd(), F3_ADD, rand_src(), 12'(next_rand())));
    emit(i_word(OPC_OPIMM, rand_rd(), F3_XOR, rand_src(), 12'(next_rand())));
    emit(i_word(OPC_OPIMM, rand_rd(), F3_OR, rand_src(), 12'(next_rand())));
    emit(i_word(OPC_OPIMM, rand_rd(), F3_AND, rand_src(), 12'(next_rand())));
    emit(i_word(OPC_OPIMM, rand_rd(), F3_SLT, rand_src(), 12'(next_rand())));
    emit(r_word(rand_rd(), F3_ADD, rand_src(), rand_src(), 7'h00));
    emit(r_word(rand_rd(), F3_ADD, rand_src(), rand_src(), 7'h20));
    emit(r_word(rand_rd(), F3_AND, rand_src(), rand_src(), 7'h00));
    emit(r_word(rand_rd(), F3_OR, rand_src(), rand_src(), 7'h00));
    emit(r_word(rand_rd(), F3_XOR, rand_src(), rand_src(), 7'h00));
    emit(r_word(rand_rd(), F3_SLT, rand_src(), rand_src(), 7'h00));
    // x0 targets, then read x0 back through an add
    emit(i_word(OPC_OPIMM, 5'd0, F3_ADD, 5'd1, 12'(next_rand())));
    emit(r_word(5'd0, F3_ADD, 5'd1, 5'd2, 7'h00));
    emit(r_word(5'd13, F3_ADD, 5'd0, 5'd1, 7'h00));
    release_reset();
    run_program(N_ARITH);
  endtask

  task automatic upper_immediates();
    start_test();
    emit(u_word(OPC_LUI, 5'd1, 20'(next_rand()) & 20'h7FFFF));
    emit(u_word(OPC_AUIPC, 5'd2, 20'(next_rand()) & 20'h7FFFF));
    emit(u_word(OPC_LUI, 5'd3, 20'(next_rand()) | 20'h80000));
    emit(u_word(OPC_AUIPC, 5'd4, 20'(next_rand()) | 20'h80000));
    emit(r_word(5'd5, F3_ADD, 5'd3, 5'd4, 7'h00));
    release_reset();
    run_program(N_UPPER);
  endtask

  task automatic memory_roundtrip();
    logic [11:0]    off_b;
    logic [11:0]    off_h;
    logic [11:0]    off_w;
    logic [11:0]    off_d;
    logic [`BUS_64] got;
    logic [`BUS_64] expd;
    int             w;
    int             i;
    start_test();
    off_b = rand_offset(1);
    off_h = rand_offset(2);
    off_w = rand_offset(4);
    off_d = rand_offset(8);
    emit(i_word(OPC_OPIMM, 5'd5, F3_ADD, 5'd0, 12'd64));
    emit(u_word(OPC_LUI, 5'd6, 20'(next_rand()) | 20'h80000));
    emit(i_word(OPC_OPIMM, 5'd6, F3_ADD, 5'd6, 12'(next_rand())));
    emit(s_word(F3_SB, 5'd5, 5'd6, off_b));
    emit(s_word(F3_SH, 5'd5, 5'd6, off_h));
    emit(s_word(F3_SW, 5'd5, 5'd6, off_w));
    emit(s_word(F3_SD, 5'd5, 5'd6, off_d));
    // read back what was stored
    emit(i_word(OPC_LOAD, 5'd7, F3_LB, 5'd5, off_b));
    emit(i_word(OPC_LOAD, 5'd8, F3_LBU, 5'd5, off_h));
    emit(i_word(OPC_LOAD, 5'd9, F3_LW, 5'd5, off_w));
    emit(i_word(OPC_LOAD, 5'd10, F3_LD, 5'd5, off_d));
    emit(i_word(OPC_LOAD, 5'd11, F3_LB, 5'd5, rand_offset(1)));
    emit(i_word(OPC_LOAD, 5'd12, F3_LBU, 5'd5, rand_offset(1)));
    emit(i_word(OPC_LOAD, 5'd13, F3_LW, 5'd5, rand_offset(4)));
    emit(i_word(OPC_LOAD, 5'd14, F3_LD, 5'd5, rand_offset(8)));
    release_reset();
    run_program(N_MEM);
    // whole memory, catches bytes written outside the mask
    for (w = 0; w < 32; w++) begin
      got  = '0;
      expd = '0;
      for (i = 0; i < 8; i++) begin
        got[8*i +: 8]  = dmem[8*w + i];
        expd[8*i +: 8] = sh_mem[8*w + i];
      end
      check_word(64'(8 * w), got, expd);
    end
  endtask

  task automatic control_flow();
    start_test();
    emit(i_word(OPC_OPIMM, 5'd1, F3_ADD, 5'd0, 12'd5));
    emit(i_word(OPC_OPIMM, 5'd2, F3_ADD, 5'd0, 12'd5));
    emit(i_word(OPC_OPIMM, 5'd3, F3_ADD, 5'd0, 12'd7));
    emit(b_word(F3_BEQ, 5'd1, 5'd2, 13'd8));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd1));
    emit(b_word(F3_BNE, 5'd1, 5'd2, 13'd8));
    emit(b_word(F3_BNE, 5'd1, 5'd3, 13'd8));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd2));
    emit(b_word(F3_BEQ, 5'd1, 5'd3, 13'd8));
    emit(j_word(5'd4, 21'd12));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd3));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd4));
    // jalr target 65 drops bit 0 and lands on 64
    emit(i_word(OPC_OPIMM, 5'd5, F3_ADD, 5'd0, 12'd60));
    emit(i_word(OPC_JALR, 5'd6, 3'b000, 5'd5, 12'd5));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd5));
    emit(i_word(OPC_OPIMM, 5'd10, F3_ADD, 5'd0, 12'd6));
    // fence ignores its rd field, so a nonzero one must not write
    emit(i_word(OPC_FENCE, 5'd9, 3'b000, 5'd0, 12'd0));
    emit(i_word(OPC_SYSTEM, 5'd0, 3'b000, 5'd0, 12'd0));
    emit(r_word(5'd7, F3_ADD, 5'd4, 5'd6, 7'h00));
    release_reset();
    run_program(N_CTRL);
  endtask

  initial begin
    rst = 1'b1;
    arith_sequence();
    upper_immediates();
    memory_roundtrip();
    control_flow();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule
